//--- compile.f
+incdir+logic
logic/decoder_pkg.sv
logic/decode_ctrl.sv
logic/inst_classify.sv
logic/ctrl_table.sv
logic/imm_gen.sv
logic/decode_stage.sv
testbench/tb_decode_stage.sv

//--- testbench/tb_decode_stage.sv
// ##########################################################
// decode stage testbench
// table of instruction words and expected decode, applied
// through the handshake with random output back-pressure
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module tb_decode_stage;

    import decoder_pkg::*;

    localparam int MAX_ENTRIES = 32;
    localparam int TIMEOUT     = 200;  // cycles per handshake

    logic                  clk = 1'b0;
    logic                  rst;
    logic                  in_valid;
    logic                  in_ready;
    logic [`INST_W-1:0]    instr;
    logic                  out_valid;
    logic                  out_ready;
    logic [`REG_IDX_W-1:0] rs1_idx;
    logic [`REG_IDX_W-1:0] rs2_idx;
    logic [`REG_IDX_W-1:0] rd_idx;
    logic                  vm;
    logic [3:0]            func_code;
    logic [5:0]            func6;
    logic [`XLEN-1:0]      imm;
    logic                  illegal;
    exe_op_e               exe_op;
    vec_operand_e          vec_operand;
    mem_op_e               mem_op;
    data_size_e            data_size;
    vls_type_e             vls_type;
    branch_e               branch_kind;
    wb_e                   wb_sel;

    // expected decode per entry
    logic [`INST_W-1:0] tbl_instr   [MAX_ENTRIES];
    logic [25:0]        tbl_fields  [MAX_ENTRIES];  // func6, vm, func_code, rs1, rs2, rd
    logic [`XLEN-1:0]   tbl_imm     [MAX_ENTRIES];
    logic               tbl_illegal [MAX_ENTRIES];
    exe_op_e            tbl_exe     [MAX_ENTRIES];
    vec_operand_e       tbl_vop     [MAX_ENTRIES];
    mem_op_e            tbl_mem     [MAX_ENTRIES];
    data_size_e         tbl_size    [MAX_ENTRIES];
    vls_type_e          tbl_vls     [MAX_ENTRIES];
    branch_e            tbl_br      [MAX_ENTRIES];
    wb_e                tbl_wb      [MAX_ENTRIES];

    int     n_entries    = 0;
    int     accepted_cnt = 0;
    int     cur_entry    = 0;
    integer seed         = 98;

    decode_stage i_decode_stage (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .instr       (instr),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rd_idx      (rd_idx),
        .vm          (vm),
        .func_code   (func_code),
        .func6       (func6),
        .imm         (imm),
        .illegal     (illegal),
        .exe_op      (exe_op),
        .vec_operand (vec_operand),
        .mem_op      (mem_op),
        .data_size   (data_size),
        .vls_type    (vls_type),
        .branch_kind (branch_kind),
        .wb_sel      (wb_sel)
    );

    always #4 clk = ~clk;

    // back-pressure on roughly one cycle in four
    always @(posedge clk) begin
        if (rst) begin
            out_ready <= 1'b0;
        end else begin
            out_ready <= (($random(seed) & 3) != 0);
        end
    end

    task automatic add_entry(input logic [`INST_W-1:0] w, input logic [`XLEN-1:0] i,
                             input logic ill, input exe_op_e e, input vec_operand_e v,
                             input mem_op_e m, input data_size_e s, input vls_type_e l,
                             input branch_e b, input wb_e wb, input logic [25:0] f);
        tbl_instr[n_entries]   = w;
        tbl_fields[n_entries]  = f;
        tbl_imm[n_entries]     = i;
        tbl_illegal[n_entries] = ill;
        tbl_exe[n_entries]     = e;
        tbl_vop[n_entries]     = v;
        tbl_mem[n_entries]     = m;
        tbl_size[n_entries]    = s;
        tbl_vls[n_entries]     = l;
        tbl_br[n_entries]      = b;
        tbl_wb[n_entries]      = wb;
        n_entries++;
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s = %h, expected %h (entry %0d)",
                     $time, name, got, exp, cur_entry);
            $display("Test FAILED");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what, input int idx);
        $display("Timeout: entry %0d was never %s", idx, what);
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_outputs(input int k);
        logic [25:0] f;
        f = tbl_fields[k];
        check_val("rs1_idx", rs1_idx, f[14:10]);
        check_val("rs2_idx", rs2_idx, f[9:5]);
        check_val("rd_idx", rd_idx, f[4:0]);
        check_val("vm", vm, f[19]);
        check_val("func_code", func_code, f[18:15]);
        check_val("func6", func6, f[25:20]);
        check_val("imm", imm, tbl_imm[k]);
        check_val("illegal", illegal, tbl_illegal[k]);
        check_val("exe_op", exe_op, tbl_exe[k]);
        check_val("vec_operand", vec_operand, tbl_vop[k]);
        check_val("mem_op", mem_op, tbl_mem[k]);
        check_val("data_size", data_size, tbl_size[k]);
        check_val("vls_type", vls_type, tbl_vls[k]);
        check_val("branch_kind", branch_kind, tbl_br[k]);
        check_val("wb_sel", wb_sel, tbl_wb[k]);
    endtask

    task automatic fill_table();
        // scalar groups
        add_entry(32'h002081B3, 64'h0, 0, EXE_BINARY, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // add x3,x1,x2
                  {6'h00, 1'b0, 4'h0, 5'd1, 5'd2, 5'd3});
        add_entry(32'h4035D513, 64'h0, 0, EXE_IMM_BINARY, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // srai x10,x11,3
                  {6'h10, 1'b0, 4'hD, 5'd11, 5'd3, 5'd10});
        add_entry(32'h0062823B, 64'h0, 0, EXE_BINARY_WORD, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // addw
                  {6'h00, 1'b0, 4'h0, 5'd5, 5'd6, 5'd4});
        add_entry(32'hFFF10093, 64'hFFFF_FFFF_FFFF_FFFF, 0, EXE_IMM_BINARY, VOP_NONE,
                  MEM_NONE, SIZE_NONE, VLS_NONE, BR_NONE, WB_ARITH, // addi x1,x2,-1
                  {6'h3F, 1'b1, 4'h8, 5'd2, 5'd31, 5'd1});
        add_entry(32'h0641811B, 64'h64, 0, EXE_IMM_BINARY_WORD, VOP_NONE, MEM_NONE,
                  SIZE_NONE, VLS_NONE, BR_NONE, WB_ARITH,           // addiw x2,x3,100
                  {6'h01, 1'b1, 4'h0, 5'd3, 5'd4, 5'd2});
        add_entry(32'hFFC30283, 64'hFFFF_FFFF_FFFF_FFFC, 0, EXE_MEM_ADDR, VOP_NONE,
                  MEM_LOAD, SIZE_BYTE, VLS_NONE, BR_NONE, WB_MEM,   // lb x5,-4(x6)
                  {6'h3F, 1'b1, 4'h8, 5'd6, 5'd28, 5'd5});
        add_entry(32'h00809383, 64'h8, 0, EXE_MEM_ADDR, VOP_NONE, MEM_LOAD, SIZE_HALF,
                  VLS_NONE, BR_NONE, WB_MEM,                        // lh x7,8(x1)
                  {6'h00, 1'b0, 4'h1, 5'd1, 5'd8, 5'd7});
        add_entry(32'h7FF12483, 64'h7FF, 0, EXE_MEM_ADDR, VOP_NONE, MEM_LOAD, SIZE_WORD,
                  VLS_NONE, BR_NONE, WB_MEM,                        // lw x9,2047(x2)
                  {6'h1F, 1'b1, 4'hA, 5'd2, 5'd31, 5'd9});
        add_entry(32'hFE512C23, 64'hFFFF_FFFF_FFFF_FFF8, 0, EXE_MEM_ADDR, VOP_NONE,
                  MEM_STORE, SIZE_WORD, VLS_NONE, BR_NONE, WB_NONE, // sw x5,-8(x2)
                  {6'h3F, 1'b1, 4'hA, 5'd2, 5'd5, 5'd24});
        add_entry(32'hFE2088E3, 64'hFFFF_FFFF_FFFF_FFF0, 0, EXE_BRANCH_COND, VOP_NONE,
                  MEM_NONE, SIZE_NONE, VLS_NONE, BR_CONDITIONAL, WB_NONE, // beq -16
                  {6'h3F, 1'b1, 4'h8, 5'd1, 5'd2, 5'd17});
        add_entry(32'h800002B7, 64'hFFFF_FFFF_8000_0000, 0, EXE_IMM, VOP_NONE, MEM_NONE,
                  SIZE_NONE, VLS_NONE, BR_NONE, WB_ARITH,           // lui x5,0x80000
                  {6'h20, 1'b0, 4'h0, 5'd0, 5'd0, 5'd5});
        add_entry(32'h12345317, 64'h1234_5000, 0, EXE_PC_BASED, VOP_NONE, MEM_NONE,
                  SIZE_NONE, VLS_NONE, BR_NONE, WB_ARITH,           // auipc
                  {6'h04, 1'b1, 4'h5, 5'd8, 5'd3, 5'd6});
        add_entry(32'h801FF0EF, 64'hFFFF_FFFF_FFFF_F800, 0, EXE_PC_BASED, VOP_NONE,
                  MEM_NONE, SIZE_NONE, VLS_NONE, BR_UNCONDITIONAL, WB_PC_INC, // jal
                  {6'h20, 1'b0, 4'h7, 5'd31, 5'd1, 5'd1});
        add_entry(32'h00008067, 64'h0, 0, EXE_MEM_ADDR, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_UNCOND_RESULT, WB_PC_INC,            // jalr x0,0(x1)
                  {6'h00, 1'b0, 4'h0, 5'd1, 5'd0, 5'd0});
        // vector memory
        add_entry(32'h02056087, 64'hA, 0, EXE_MEM_ADDR, VOP_NONE, MEM_LOAD, SIZE_WORD,
                  VLS_STRIDE, BR_NONE, WB_MEM,                      // vle32.v
                  {6'h00, 1'b1, 4'h6, 5'd10, 5'd0, 5'd1});
        add_entry(32'h02818107, 64'h3, 0, EXE_MEM_ADDR, VOP_NONE, MEM_LOAD, SIZE_BYTE,
                  VLS_WHOLE_REG, BR_NONE, WB_MEM,                   // vl1re8.v
                  {6'h00, 1'b1, 4'h0, 5'd3, 5'd8, 5'd2});
        add_entry(32'h02B8D227, 64'hFFFF_FFFF_FFFF_FFF1, 0, EXE_MEM_ADDR, VOP_NONE,
                  MEM_STORE, SIZE_HALF, VLS_MASK, BR_NONE, WB_NONE, // mask store
                  {6'h00, 1'b1, 4'h5, 5'd17, 5'd11, 5'd4});
        // vector arithmetic, one per funct3 group
        add_entry(32'h002180D7, 64'h3, 0, EXE_BINARY, VOP_VEC_VEC, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // vadd.vv masked
                  {6'h00, 1'b0, 4'h0, 5'd3, 5'd2, 5'd1});
        add_entry(32'h9642A357, 64'h5, 0, EXE_BINARY, VOP_VEC_VEC, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // vmul.vv
                  {6'h25, 1'b1, 4'h2, 5'd5, 5'd4, 5'd6});
        add_entry(32'h022EB0D7, 64'hFFFF_FFFF_FFFF_FFFD, 0, EXE_IMM_BINARY, VOP_VEC_IMM,
                  MEM_NONE, SIZE_NONE, VLS_NONE, BR_NONE, WB_ARITH, // vadd.vi -3
                  {6'h00, 1'b1, 4'h3, 5'd29, 5'd2, 5'd1});
        add_entry(32'h028644D7, 64'hC, 0, EXE_BINARY, VOP_VEC_SCALAR, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // vadd.vx
                  {6'h00, 1'b1, 4'h4, 5'd12, 5'd8, 5'd9});
        add_entry(32'h9613E157, 64'h7, 0, EXE_BINARY, VOP_VEC_SCALAR, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_ARITH,                      // vmul.vx
                  {6'h25, 1'b1, 4'h6, 5'd7, 5'd1, 5'd2});
        // illegal words
        add_entry(32'h1234567F, 64'h0, 1, EXE_NONE, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_NONE,                       // unknown opcode
                  {6'h04, 1'b1, 4'h5, 5'd8, 5'd3, 5'd12});
        add_entry(32'h010572D7, 64'h0, 1, EXE_NONE, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_NONE,                       // vsetvli
                  {6'h00, 1'b0, 4'h7, 5'd10, 5'd16, 5'd5});
        add_entry(32'h00013083, 64'h0, 1, EXE_NONE, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_NONE,                       // ld, funct3 011
                  {6'h00, 1'b0, 4'h3, 5'd2, 5'd0, 5'd1});
        add_entry(32'h02108087, 64'h0, 1, EXE_NONE, VOP_NONE, MEM_NONE, SIZE_NONE,
                  VLS_NONE, BR_NONE, WB_NONE,                       // lumop 00001
                  {6'h00, 1'b1, 4'h0, 5'd1, 5'd1, 5'd1});
    endtask

    task automatic drive_entries();
        int cycles;
        for (int i = 0; i < n_entries; i++) begin
            in_valid <= 1'b1;
            instr    <= tbl_instr[i];
            cycles = 0;
            do begin
                @(posedge clk);
                cycles++;
                if (!in_ready && cycles > TIMEOUT) begin
                    report_timeout("accepted", i);
                end
            end while (!in_ready);
            accepted_cnt++;
        end
        in_valid <= 1'b0;
    endtask

    task automatic monitor_outputs();
        int  cycles;
        bit  done;
        for (int k = 0; k < n_entries; k++) begin
            cycles = 0;
            done   = 0;
            while (!done) begin
                @(negedge clk);
                cur_entry = k;
                // one word in flight exactly when accepted but not yet consumed
                check_val("out_valid", out_valid, accepted_cnt > k);
                if (out_valid && !out_ready) begin
                    check_val("in_ready", in_ready, 1'b0);
                end
                if (!out_valid) begin
                    check_val("in_ready", in_ready, 1'b1);
                end
                if (out_valid) begin
                    check_outputs(k);
                end
                done = out_valid && out_ready;
                cycles++;
                if (!done && cycles > TIMEOUT) begin
                    report_timeout("handed off at the output", k);
                end
            end
        end
        @(negedge clk);
        check_val("out_valid", out_valid, 1'b0);  // nothing repeated
    endtask

    initial begin
        rst       = 1'b1;
        in_valid  = 1'b0;
        instr     = '0;
        out_ready = 1'b0;
        fill_table();
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("out_valid", out_valid, 1'b0);
        check_val("in_ready", in_ready, 1'b1);
        @(posedge clk);
        fork
            drive_entries();
            monitor_outputs();
        join
        $display("Test OK");
        $finish;
    end

endmodule

//--- logic/decode_stage.sv
// ##########################################################
// decode stage
// registered rv64 + vector decode behind a valid/ready pair
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module decode_stage (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  logic [`INST_W-1:0]          instr,
    output logic                        out_valid,
    input  logic                        out_ready,
    output logic [`REG_IDX_W-1:0]       rs1_idx,
    output logic [`REG_IDX_W-1:0]       rs2_idx,
    output logic [`REG_IDX_W-1:0]       rd_idx,
    output logic                        vm,
    output logic [3:0]                  func_code,
    output logic [5:0]                  func6,
    output logic [`XLEN-1:0]            imm,
    output logic                        illegal,
    output decoder_pkg::exe_op_e        exe_op,
    output decoder_pkg::vec_operand_e   vec_operand,
    output decoder_pkg::mem_op_e        mem_op,
    output decoder_pkg::data_size_e     data_size,
    output decoder_pkg::vls_type_e      vls_type,
    output decoder_pkg::branch_e        branch_kind,
    output decoder_pkg::wb_e            wb_sel
);

    import decoder_pkg::*;

    logic [`INST_W-1:0] held_instr;
    inst_format_e       fmt;

    // raw fields straight from the held word
    assign rs1_idx   = held_instr[19:15];
    assign rs2_idx   = held_instr[24:20];
    assign rd_idx    = held_instr[11:7];
    assign vm        = held_instr[25];
    assign func_code = {held_instr[30], held_instr[14:12]};
    assign func6     = held_instr[31:26];

    decode_ctrl i_decode_ctrl (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .instr      (instr),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .held_instr (held_instr)
    );

    inst_classify i_inst_classify (
        .held_instr (held_instr),
        .fmt        (fmt)
    );

    ctrl_table i_ctrl_table (
        .held_instr  (held_instr),
        .fmt         (fmt),
        .exe_op      (exe_op),
        .vec_operand (vec_operand),
        .mem_op      (mem_op),
        .data_size   (data_size),
        .vls_type    (vls_type),
        .branch_kind (branch_kind),
        .wb_sel      (wb_sel),
        .illegal     (illegal)
    );

    imm_gen i_imm_gen (
        .held_instr (held_instr),
        .fmt        (fmt),
        .illegal    (illegal),
        .imm        (imm)
    );

endmodule

//--- logic/imm_gen.sv
// ##########################################################
// immediate generator
// sign-extended 64-bit immediate for the decoded format
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module imm_gen (
    input  logic [`INST_W-1:0]        held_instr,
    input  decoder_pkg::inst_format_e fmt,
    input  logic                      illegal,
    output logic [`XLEN-1:0]          imm
);

    import decoder_pkg::*;

    logic sign;

    assign sign = held_instr[31];

    always_comb begin
        case (fmt)
            FMT_V: imm = {{(`XLEN-5){held_instr[19]}}, held_instr[19:15]};  // simm5
            FMT_I: imm = {{(`XLEN-12){sign}}, held_instr[31:20]};
            FMT_S: imm = {{(`XLEN-12){sign}}, held_instr[31:25], held_instr[11:7]};
            FMT_B: begin
                imm = {{(`XLEN-12){sign}}, held_instr[7], held_instr[30:25],
                       held_instr[11:8], 1'b0};
            end
            FMT_U: imm = {{(`XLEN-32){sign}}, held_instr[31:12], 12'b0};
            FMT_J: begin
                imm = {{(`XLEN-20){sign}}, held_instr[19:12], held_instr[20],
                       held_instr[30:21], 1'b0};
            end
            default: imm = '0;  // R format and none
        endcase
        if (illegal) begin
            imm = '0;
        end
    end

endmodule

//--- logic/ctrl_table.sv
// ##########################################################
// control table
// maps format, opcode and funct fields to control fields
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module ctrl_table (
    input  logic [`INST_W-1:0]        held_instr,
    input  decoder_pkg::inst_format_e fmt,
    output decoder_pkg::exe_op_e      exe_op,
    output decoder_pkg::vec_operand_e vec_operand,
    output decoder_pkg::mem_op_e      mem_op,
    output decoder_pkg::data_size_e   data_size,
    output decoder_pkg::vls_type_e    vls_type,
    output decoder_pkg::branch_e      branch_kind,
    output decoder_pkg::wb_e          wb_sel,
    output logic                      illegal
);

    import decoder_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [4:0] lumop;

    assign opcode = held_instr[6:0];
    assign funct3 = held_instr[14:12];
    assign lumop  = held_instr[24:20];

    function automatic data_size_e scalar_size(input logic [2:0] f3);
        case (f3)
            3'b000:  return SIZE_BYTE;
            3'b001:  return SIZE_HALF;
            3'b010:  return SIZE_WORD;
            default: return SIZE_NONE;
        endcase
    endfunction

    // vector width field uses its own encoding
    function automatic data_size_e vector_size(input logic [2:0] f3);
        case (f3)
            3'b000:  return SIZE_BYTE;
            3'b101:  return SIZE_HALF;
            3'b110:  return SIZE_WORD;
            default: return SIZE_NONE;
        endcase
    endfunction

    function automatic vls_type_e lumop_type(input logic [4:0] lop);
        case (lop)
            `LUMOP_BASIC:     return VLS_STRIDE;
            `LUMOP_WHOLE_REG: return VLS_WHOLE_REG;
            `LUMOP_MASK:      return VLS_MASK;
            default:          return VLS_NONE;
        endcase
    endfunction

    always_comb begin
        exe_op      = EXE_NONE;
        vec_operand = VOP_NONE;
        mem_op      = MEM_NONE;
        data_size   = SIZE_NONE;
        vls_type    = VLS_NONE;
        branch_kind = BR_NONE;
        wb_sel      = WB_NONE;
        illegal     = 1'b0;
        case (fmt)
            FMT_V: begin
                case (opcode)
                    `OPC_VL, `OPC_VS: begin
                        exe_op    = EXE_MEM_ADDR;
                        mem_op    = (opcode == `OPC_VL) ? MEM_LOAD : MEM_STORE;
                        wb_sel    = (opcode == `OPC_VL) ? WB_MEM : WB_NONE;
                        data_size = vector_size(funct3);
                        vls_type  = lumop_type(lumop);
                        illegal   = (data_size == SIZE_NONE) || (vls_type == VLS_NONE);
                    end
                    `OPC_VARITH: begin
                        wb_sel = WB_ARITH;
                        case (funct3)
                            `F3_OPIVV, `F3_OPMVV: begin
                                exe_op      = EXE_BINARY;
                                vec_operand = VOP_VEC_VEC;
                            end
                            `F3_OPIVI: begin
                                exe_op      = EXE_IMM_BINARY;
                                vec_operand = VOP_VEC_IMM;
                            end
                            `F3_OPIVX, `F3_OPMVX: begin
                                exe_op      = EXE_BINARY;
                                vec_operand = VOP_VEC_SCALAR;
                            end
                            default: illegal = 1'b1;  // float groups, opcfg
                        endcase
                    end
                    default: illegal = 1'b1;
                endcase
            end
            FMT_R: begin
                wb_sel = WB_ARITH;
                case (opcode)
                    `OPC_OP:     exe_op = EXE_BINARY;
                    `OPC_OP_IMM: exe_op = EXE_IMM_BINARY;  // shift-immediate
                    `OPC_OP_32:  exe_op = EXE_BINARY_WORD;
                    default:     illegal = 1'b1;
                endcase
            end
            FMT_I: begin
                case (opcode)
                    `OPC_OP_IMM: begin
                        exe_op = EXE_IMM_BINARY;
                        wb_sel = WB_ARITH;
                    end
                    `OPC_OP_IMM_32: begin
                        exe_op = EXE_IMM_BINARY_WORD;  // addiw
                        wb_sel = WB_ARITH;
                    end
                    `OPC_LOAD: begin
                        exe_op    = EXE_MEM_ADDR;
                        mem_op    = MEM_LOAD;
                        wb_sel    = WB_MEM;
                        data_size = scalar_size(funct3);
                        illegal   = (data_size == SIZE_NONE);
                    end
                    `OPC_JALR: begin
                        exe_op      = EXE_MEM_ADDR;
                        branch_kind = BR_UNCOND_RESULT;
                        wb_sel      = WB_PC_INC;
                    end
                    default: illegal = 1'b1;
                endcase
            end
            FMT_S: begin
                exe_op    = EXE_MEM_ADDR;
                mem_op    = MEM_STORE;
                data_size = scalar_size(funct3);
                illegal   = (data_size == SIZE_NONE);
            end
            FMT_B: begin
                exe_op      = EXE_BRANCH_COND;
                branch_kind = BR_CONDITIONAL;
            end
            FMT_U: begin
                exe_op = (opcode == `OPC_LUI) ? EXE_IMM : EXE_PC_BASED;
                wb_sel = WB_ARITH;
            end
            FMT_J: begin
                exe_op      = EXE_PC_BASED;
                branch_kind = BR_UNCONDITIONAL;
                wb_sel      = WB_PC_INC;
            end
            default: illegal = 1'b1;
        endcase

        // an illegal word carries no partial decode
        if (illegal) begin
            exe_op      = EXE_NONE;
            vec_operand = VOP_NONE;
            mem_op      = MEM_NONE;
            data_size   = SIZE_NONE;
            vls_type    = VLS_NONE;
            branch_kind = BR_NONE;
            wb_sel      = WB_NONE;
        end
    end

endmodule

//--- logic/inst_classify.sv
// ##########################################################
// instruction classifier
// picks the encoding format of the held instruction
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module inst_classify (
    input  logic [`INST_W-1:0]        held_instr,
    output decoder_pkg::inst_format_e fmt
);

    import decoder_pkg::*;

    logic [6:0] opcode;
    logic [3:0] func_code;
    logic       shift_fc;

    assign opcode    = held_instr[6:0];
    assign func_code = {held_instr[30], held_instr[14:12]};
    // slli, srli, srai
    assign shift_fc  = (func_code == 4'b0001) || (func_code == 4'b0101) ||
                       (func_code == 4'b1101);

    always_comb begin
        fmt = FMT_NONE;
        case (opcode)
            `OPC_VL, `OPC_VS, `OPC_VARITH: fmt = FMT_V;
            `OPC_OP, `OPC_OP_32:           fmt = FMT_R;
            `OPC_OP_IMM: begin
                if (shift_fc) begin
                    fmt = FMT_R;  // shamt is not an immediate here
                end else begin
                    fmt = FMT_I;
                end
            end
            `OPC_LOAD: fmt = FMT_I;
            `OPC_JALR, `OPC_OP_IMM_32: begin
                if (func_code[2:0] == 3'b000) begin
                    fmt = FMT_I;
                end
            end
            `OPC_STORE:            fmt = FMT_S;
            `OPC_BRANCH:           fmt = FMT_B;
            `OPC_LUI, `OPC_AUIPC:  fmt = FMT_U;
            `OPC_JAL:              fmt = FMT_J;
            default:               fmt = FMT_NONE;
        endcase
    end

endmodule

//--- logic/decode_ctrl.sv
// ##########################################################
// decode control
// valid/ready handshake and the held instruction register
// ##########################################################
`timescale 1ns/1ps
`include "decoder_defs.svh"

module decode_ctrl (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [`INST_W-1:0] instr,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [`INST_W-1:0] held_instr
);

    logic accept;

    // a new word may enter in the cycle the old one leaves
    assign in_ready = !out_valid || out_ready;
    assign accept   = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else if (in_ready) begin
            out_valid <= in_valid;  // drops when consumed with nothing behind
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            held_instr <= instr;
        end
    end

    // stalled output must hold the same word
    a_stall_hold: assert property (
        @(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(held_instr)
    );

    // accepted word is presented one cycle later
    a_accept_load: assert property (
        @(posedge clk) disable iff (rst)
        accept |=> out_valid && held_instr == $past(instr)
    );

endmodule

//--- logic/decoder_pkg.sv
// ##########################################################
// decoder package
// enum types for the instruction format and control fields
// ##########################################################
package decoder_pkg;

    typedef enum logic [2:0] {
        FMT_V,
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_NONE
    } inst_format_e;

    typedef enum logic [3:0] {
        EXE_NONE,
        EXE_BINARY,
        EXE_IMM_BINARY,
        EXE_BINARY_WORD,
        EXE_IMM_BINARY_WORD,
        EXE_MEM_ADDR,     // address add for load/store/jalr
        EXE_BRANCH_COND,
        EXE_IMM,
        EXE_PC_BASED
    } exe_op_e;

    typedef enum logic [1:0] {
        VOP_NONE,
        VOP_VEC_VEC,
        VOP_VEC_IMM,
        VOP_VEC_SCALAR
    } vec_operand_e;

    typedef enum logic [1:0] {MEM_NONE, MEM_LOAD, MEM_STORE} mem_op_e;

    typedef enum logic [1:0] {SIZE_NONE, SIZE_BYTE, SIZE_HALF, SIZE_WORD} data_size_e;

    typedef enum logic [1:0] {VLS_NONE, VLS_STRIDE, VLS_WHOLE_REG, VLS_MASK} vls_type_e;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_CONDITIONAL,
        BR_UNCONDITIONAL,
        BR_UNCOND_RESULT  // target comes from the alu result
    } branch_e;

    typedef enum logic [1:0] {WB_NONE, WB_ARITH, WB_MEM, WB_PC_INC} wb_e;

endpackage

//--- logic/decoder_defs.svh
// ##########################################################
// decoder definitions
// widths, opcode encodings, vector funct3 groups and lumops
// ##########################################################
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

`define XLEN        64
`define INST_W      32
`define REG_IDX_W   5

// base opcodes
`define OPC_OP         7'b0110011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP_32      7'b0111011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_BRANCH     7'b1100011
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_VL         7'b0000111
`define OPC_VS         7'b0100111
`define OPC_VARITH     7'b1010111

`define F3_OPIVV  3'b000
`define F3_OPMVV  3'b010
`define F3_OPIVI  3'b011
`define F3_OPIVX  3'b100
`define F3_OPMVX  3'b110

`define LUMOP_BASIC      5'b00000
`define LUMOP_WHOLE_REG  5'b01000
`define LUMOP_MASK       5'b01011  // mask load/store

`endif
